/* include/alu_macros.svh */
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

// operand and result width of the execute unit.
`define ALU_WIDTH 32

// one-hot operation word, one bit per alu_op_e entry.
`define OP_WIDTH 21

// eight-bit chunks of the second operand.
`define MUL_STEPS 4

// two quotient bits per step.
`define DIV_STEPS 16

`endif

/* source/alu_pkg.sv */
package alu_pkg;

  // bit positions inside the one-hot operation word.
  typedef enum logic [4:0] {
    op_add    = 5'd0,
    op_sub    = 5'd1,
    op_sll    = 5'd2,
    op_srl    = 5'd3,
    op_sra    = 5'd4,
    op_or     = 5'd5,
    op_and    = 5'd6,
    op_xor    = 5'd7,
    op_slt    = 5'd8,
    op_sltu   = 5'd9,
    op_mul    = 5'd10,
    op_mulh   = 5'd11,
    op_mulhsu = 5'd12,
    op_mulhu  = 5'd13,
    op_div    = 5'd14,
    op_divu   = 5'd15,
    op_rem    = 5'd16,
    op_remu   = 5'd17,
    op_beq    = 5'd18,
    op_blt    = 5'd19,
    op_branch = 5'd20
  } alu_op_e;

  typedef enum logic [1:0] {
    seq_idle,
    seq_run_mul,
    seq_run_div,
    seq_finish
  } seq_state_e;

  typedef enum logic [1:0] {
    mul_ss, // both operands signed.
    mul_su, // first signed, second unsigned.
    mul_uu
  } mul_kind_e;

endpackage

/* source/iterate_if.sv */
interface iterate_if;

  logic       init;    // first cycle of a run.
  logic       advance; // one working step.
  logic       last;    // closing cycle after the final step.
  logic [3:0] step;

  modport ctrl (
    output init,
    output advance,
    output last,
    output step
  );

  modport unit (
    input init,
    input advance,
    input last,
    input step
  );

endinterface

/* source/step_counter.sv */
`include "alu_macros.svh"

module step_counter (
  input  logic       clk,
  input  logic       resetn,
  input  logic       clear,
  input  logic       enable,
  input  logic       is_div,
  output logic [3:0] count,
  output logic       terminal
);

  logic [3:0] limit;

  assign limit    = is_div ? 4'(`DIV_STEPS - 1) : 4'(`MUL_STEPS - 1);
  assign terminal = (count == limit);

  always_ff @(posedge clk)
  begin
    if (!resetn)
      count <= '0;
    else if (clear)
      count <= '0;
    else if (enable)
      count <= count + 4'd1; // a divide run wraps back to zero by itself.
  end

endmodule

/* source/alu_sequencer.sv */
`include "alu_macros.svh"

module alu_sequencer (
  input  logic                 clk,
  input  logic                 resetn,
  input  logic [`OP_WIDTH-1:0] alu_op,
  iterate_if.ctrl              mul_it,
  iterate_if.ctrl              div_it,
  output logic                 done
);

  import alu_pkg::*;

  seq_state_e state;
  seq_state_e state_next;
  logic       mul_sel;
  logic       div_sel;
  logic       start_mul;
  logic       start_div;
  logic       div_mode;
  logic       last_q;
  logic       cnt_clear;
  logic       cnt_enable;
  logic       cnt_terminal;
  logic [3:0] cnt;

  assign mul_sel = alu_op[op_mul] | alu_op[op_mulh] | alu_op[op_mulhsu] | alu_op[op_mulhu];
  assign div_sel = alu_op[op_div] | alu_op[op_divu] | alu_op[op_rem] | alu_op[op_remu];

  // no start while done is high, so the driver has a cycle to drop the operation.
  assign start_mul = (state == seq_idle) & mul_sel & ~done;
  assign start_div = (state == seq_idle) & div_sel & ~mul_sel & ~done;

  // step 0 of a multiply runs together with its init.
  assign mul_it.init    = start_mul;
  assign mul_it.advance = start_mul | (state == seq_run_mul);
  assign mul_it.last    = (state == seq_finish) & ~div_mode;
  assign mul_it.step    = cnt;

  assign div_it.init    = start_div;
  assign div_it.advance = (state == seq_run_div);
  assign div_it.last    = (state == seq_finish) & div_mode & ~last_q;
  assign div_it.step    = cnt;

  assign cnt_enable = mul_it.advance | div_it.advance;
  assign cnt_clear  = (state == seq_finish) | ((state == seq_idle) & ~start_mul);

  step_counter step_counter_i (
    .clk      (clk),
    .resetn   (resetn),
    .clear    (cnt_clear),
    .enable   (cnt_enable),
    .is_div   (state == seq_run_div),
    .count    (cnt),
    .terminal (cnt_terminal)
  );

  always_comb
  begin
    state_next = state;
    case (state)
      seq_idle:
      begin
        if (start_mul)
          state_next = seq_run_mul;
        else if (start_div)
          state_next = seq_run_div;
      end
      seq_run_mul, seq_run_div:
      begin
        if (cnt_terminal)
          state_next = seq_finish;
      end
      default:
      begin
        if (!div_mode || last_q)
          state_next = seq_idle; // a divide spends one extra cycle on the sign fix.
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      state    <= seq_idle;
      div_mode <= 1'b0;
      last_q   <= 1'b0;
      done     <= 1'b0;
    end
    else
    begin
      state  <= state_next;
      last_q <= div_it.last;
      done   <= (state == seq_finish) & (~div_mode | last_q);
      if (state == seq_idle)
        div_mode <= start_div;
    end
  end

endmodule

/* source/chunk_multiplier.sv */
`include "alu_macros.svh"

module chunk_multiplier (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic [`ALU_WIDTH-1:0] ain,
  input  logic [`ALU_WIDTH-1:0] bin,
  input  alu_pkg::mul_kind_e    kind,
  iterate_if.unit               it,
  output logic [2*`ALU_WIDTH-1:0] product
);

  import alu_pkg::*;

  logic [2*`ALU_WIDTH-1:0] a_ext;
  logic [2*`ALU_WIDTH-1:0] a_q;
  logic [2*`ALU_WIDTH-1:0] a_sel;
  logic [`ALU_WIDTH-1:0]   b_q;
  logic [`ALU_WIDTH-1:0]   b_sel;
  logic                    b_signed;
  logic                    b_signed_q;
  logic                    chunk_neg;
  logic [7:0]              chunk;
  logic [2*`ALU_WIDTH-1:0] chunk_ext;
  logic [2*`ALU_WIDTH-1:0] term;
  logic [2*`ALU_WIDTH-1:0] acc;

  assign a_ext    = {{`ALU_WIDTH{(kind != mul_uu) & ain[`ALU_WIDTH-1]}}, ain};
  assign b_signed = (kind == mul_ss);

  // the init cycle also carries step 0, so it takes the operands straight from the ports.
  assign a_sel = it.init ? a_ext : a_q;
  assign b_sel = it.init ? bin : b_q;

  assign chunk     = 8'(b_sel >> {it.step[1:0], 3'b000});
  assign chunk_neg = (it.init ? b_signed : b_signed_q) & (it.step[1:0] == 2'(`MUL_STEPS - 1));
  assign chunk_ext = {{(2*`ALU_WIDTH-8){chunk_neg & chunk[7]}}, chunk};
  assign term      = (a_sel * chunk_ext) << {it.step[1:0], 3'b000};

  always_ff @(posedge clk)
  begin
    if (it.init)
    begin
      a_q        <= a_ext;
      b_q        <= bin;
      b_signed_q <= b_signed;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!resetn)
      acc <= '0;
    else if (it.init)
      acc <= it.advance ? term : '0;
    else if (it.advance)
      acc <= acc + term;
  end

  always_ff @(posedge clk)
  begin
    if (it.last)
      product <= acc; // held until the next run closes.
  end

endmodule

/* source/radix4_divider.sv */
`include "alu_macros.svh"

module radix4_divider (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic [`ALU_WIDTH-1:0] dividend,
  input  logic [`ALU_WIDTH-1:0] divisor,
  input  logic                  div_unsigned,
  iterate_if.unit               it,
  output logic [`ALU_WIDTH-1:0] quotient,
  output logic [`ALU_WIDTH-1:0] remainder
);

  localparam int W = `ALU_WIDTH;

  logic         a_neg;
  logic         b_neg;
  logic [W-1:0] a_mag;
  logic [W-1:0] b_mag;
  logic [W-1:0] a_q;
  logic [W-1:0] d_q;
  logic [W:0]   r_q;
  logic [W-1:0] q_q;
  logic [2*W:0] first;
  logic [2*W:0] second;
  logic         neg_quo;
  logic         neg_rem;
  logic         zero_div;
  logic         overflow;

  // one restoring bit: shift in the next dividend bit and subtract when it fits.
  function automatic logic [2*W:0] restore_step(
    input logic [W:0]   r,
    input logic [W-1:0] q,
    input logic [W-1:0] d
  );
    logic [W:0] r_shift;
    logic [W:0] diff;
    r_shift = {r[W-1:0], q[W-1]};
    diff    = r_shift - {1'b0, d};
    if (r_shift >= {1'b0, d})
      return {diff, q[W-2:0], 1'b1};
    else
      return {r_shift, q[W-2:0], 1'b0};
  endfunction

  assign a_neg = ~div_unsigned & dividend[W-1];
  assign b_neg = ~div_unsigned & divisor[W-1];
  assign a_mag = a_neg ? -dividend : dividend;
  assign b_mag = b_neg ? -divisor : divisor;

  assign first  = restore_step(r_q, q_q, d_q);
  assign second = restore_step(first[2*W:W], first[W-1:0], d_q);

  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      neg_quo  <= 1'b0;
      neg_rem  <= 1'b0;
      zero_div <= 1'b0;
      overflow <= 1'b0;
    end
    else if (it.init)
    begin
      neg_quo  <= a_neg ^ b_neg;
      neg_rem  <= a_neg; // the remainder takes the sign of the dividend.
      zero_div <= (divisor == '0);
      overflow <= ~div_unsigned & (dividend == {1'b1, {(W-1){1'b0}}}) & (divisor == '1);
    end
  end

  always_ff @(posedge clk)
  begin
    if (it.init)
    begin
      a_q <= dividend;
      d_q <= b_mag;
      r_q <= '0;
      q_q <= a_mag;
    end
    else if (it.advance)
    begin
      r_q <= second[2*W:W];
      q_q <= second[W-1:0];
    end
  end

  always_ff @(posedge clk)
  begin
    if (it.last)
    begin
      if (zero_div)
      begin
        quotient  <= '1;
        remainder <= a_q;
      end
      else if (overflow)
      begin
        quotient  <= a_q;
        remainder <= '0;
      end
      else
      begin
        quotient  <= neg_quo ? -q_q : q_q;
        remainder <= neg_rem ? -r_q[W-1:0] : r_q[W-1:0];
      end
    end
  end

endmodule

/* source/barrel_shifter.sv */
`include "alu_macros.svh"

module barrel_shifter (
  input  logic [`ALU_WIDTH-1:0] data,
  input  logic [4:0]            amount,
  input  logic                  right,
  input  logic                  arith,
  output logic [`ALU_WIDTH-1:0] shifted
);

  logic [`ALU_WIDTH-1:0] stage0;
  logic [`ALU_WIDTH-1:0] stage1;
  logic [`ALU_WIDTH-1:0] stage2;
  logic [`ALU_WIDTH-1:0] stage3;
  logic [`ALU_WIDTH-1:0] stage4;
  logic [`ALU_WIDTH-1:0] stage5;
  logic                  fill;

  assign fill = right & arith & data[`ALU_WIDTH-1];

  // left shifts run through the same right-shift stages on the bit-reversed word.
  assign stage0 = right ? data : {<<{data}};
  assign stage1 = amount[0] ? {fill, stage0[`ALU_WIDTH-1:1]} : stage0;
  assign stage2 = amount[1] ? {{2{fill}}, stage1[`ALU_WIDTH-1:2]} : stage1;
  assign stage3 = amount[2] ? {{4{fill}}, stage2[`ALU_WIDTH-1:4]} : stage2;
  assign stage4 = amount[3] ? {{8{fill}}, stage3[`ALU_WIDTH-1:8]} : stage3;
  assign stage5 = amount[4] ? {{16{fill}}, stage4[`ALU_WIDTH-1:16]} : stage4;

  assign shifted = right ? stage5 : {<<{stage5}};

endmodule

/* source/alu_datapath.sv */
`include "alu_macros.svh"

module alu_datapath (
  input  logic [`ALU_WIDTH-1:0]   ain,
  input  logic [`ALU_WIDTH-1:0]   bin,
  input  logic [`OP_WIDTH-1:0]    alu_op,
  input  logic [2*`ALU_WIDTH-1:0] product,
  input  logic [`ALU_WIDTH-1:0]   quotient,
  input  logic [`ALU_WIDTH-1:0]   remainder,
  input  logic [`ALU_WIDTH-1:0]   shifted,
  output alu_pkg::mul_kind_e      mul_kind,
  output logic                    div_unsigned,
  output logic                    shift_right,
  output logic                    shift_arith,
  output logic [`ALU_WIDTH-1:0]   result,
  output logic                    branch_taken
);

  import alu_pkg::*;

  logic                  sub_mode;
  logic                  sign_ext;
  logic [`ALU_WIDTH:0]   a_wide;
  logic [`ALU_WIDTH:0]   b_wide;
  logic [`ALU_WIDTH:0]   sum;
  logic                  less;
  logic                  equal;
  logic [`ALU_WIDTH-1:0] logic_res;

  assign sub_mode = alu_op[op_sub] | alu_op[op_slt] | alu_op[op_sltu];
  assign sign_ext = ~alu_op[op_sltu];

  // bit 32 of the difference is the less-than flag.
  assign a_wide = {sign_ext & ain[`ALU_WIDTH-1], ain};
  assign b_wide = {sign_ext & bin[`ALU_WIDTH-1], bin} ^ {(`ALU_WIDTH+1){sub_mode}};
  assign sum    = a_wide + b_wide + {{`ALU_WIDTH{1'b0}}, sub_mode};
  assign less   = sum[`ALU_WIDTH];
  assign equal  = (sum[`ALU_WIDTH-1:0] == '0);

  assign logic_res = ({`ALU_WIDTH{alu_op[op_or] | alu_op[op_xor]}} & (ain ^ bin)) |
                     ({`ALU_WIDTH{alu_op[op_or] | alu_op[op_and]}} & (ain & bin));

  assign shift_right  = alu_op[op_srl] | alu_op[op_sra];
  assign shift_arith  = alu_op[op_sra];
  assign div_unsigned = alu_op[op_divu] | alu_op[op_remu];

  always_comb
  begin
    if (alu_op[op_mulhsu])
      mul_kind = mul_su;
    else if (alu_op[op_mulhu])
      mul_kind = mul_uu;
    else
      mul_kind = mul_ss;
  end

  always_comb
  begin
    if (alu_op[op_add] | alu_op[op_sub])
      result = sum[`ALU_WIDTH-1:0];
    else if (alu_op[op_slt] | alu_op[op_sltu])
      result = {{(`ALU_WIDTH-1){1'b0}}, less};
    else if (alu_op[op_or] | alu_op[op_and] | alu_op[op_xor])
      result = logic_res;
    else if (alu_op[op_sll] | alu_op[op_srl] | alu_op[op_sra])
      result = shifted;
    else if (alu_op[op_mul])
      result = product[`ALU_WIDTH-1:0];
    else if (alu_op[op_mulh] | alu_op[op_mulhsu] | alu_op[op_mulhu])
      result = product[2*`ALU_WIDTH-1:`ALU_WIDTH]; // high word for every mulh flavour.
    else if (alu_op[op_div] | alu_op[op_divu])
      result = quotient;
    else if (alu_op[op_rem] | alu_op[op_remu])
      result = remainder;
    else
      result = '0;
  end

  // beq and blt pick the sense, clearing them gives bne and bge.
  assign branch_taken = alu_op[op_branch] &
                        ((alu_op[op_sub] & ~(alu_op[op_beq] ^ equal)) |
                         ((alu_op[op_slt] | alu_op[op_sltu]) & ~(alu_op[op_blt] ^ less)));

endmodule

/* source/int_alu.sv */
`include "alu_macros.svh"

module int_alu (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic [`ALU_WIDTH-1:0] ain,
  input  logic [`ALU_WIDTH-1:0] bin,
  input  logic [`OP_WIDTH-1:0]  alu_op,
  output logic [`ALU_WIDTH-1:0] result,
  output logic                  branch_taken,
  output logic                  done
);

  import alu_pkg::*;

  mul_kind_e               mul_kind;
  logic                    div_unsigned;
  logic                    shift_right;
  logic                    shift_arith;
  logic [2*`ALU_WIDTH-1:0] product;
  logic [`ALU_WIDTH-1:0]   quotient;
  logic [`ALU_WIDTH-1:0]   remainder;
  logic [`ALU_WIDTH-1:0]   shifted;

  iterate_if mul_it ();
  iterate_if div_it ();

  alu_sequencer alu_sequencer_i (
    .clk    (clk),
    .resetn (resetn),
    .alu_op (alu_op),
    .mul_it (mul_it.ctrl),
    .div_it (div_it.ctrl),
    .done   (done)
  );

  alu_datapath alu_datapath_i (
    .ain          (ain),
    .bin          (bin),
    .alu_op       (alu_op),
    .product      (product),
    .quotient     (quotient),
    .remainder    (remainder),
    .shifted      (shifted),
    .mul_kind     (mul_kind),
    .div_unsigned (div_unsigned),
    .shift_right  (shift_right),
    .shift_arith  (shift_arith),
    .result       (result),
    .branch_taken (branch_taken)
  );

  chunk_multiplier chunk_multiplier_i (
    .clk     (clk),
    .resetn  (resetn),
    .ain     (ain),
    .bin     (bin),
    .kind    (mul_kind),
    .it      (mul_it.unit),
    .product (product)
  );

  radix4_divider radix4_divider_i (
    .clk          (clk),
    .resetn       (resetn),
    .dividend     (ain),
    .divisor      (bin),
    .div_unsigned (div_unsigned),
    .it           (div_it.unit),
    .quotient     (quotient),
    .remainder    (remainder)
  );

  barrel_shifter barrel_shifter_i (
    .data    (ain),
    .amount  (bin[4:0]),
    .right   (shift_right),
    .arith   (shift_arith),
    .shifted (shifted)
  );

endmodule

/* bench/int_alu_tb.sv */
`include "alu_macros.svh"

module int_alu_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import alu_pkg::*;

  localparam logic [31:0] min_int        = 32'h8000_0000;
  localparam int          timeout_cycles = 40;

  logic                  clk = 1'b0;
  logic                  resetn;
  logic [`ALU_WIDTH-1:0] ain;
  logic [`ALU_WIDTH-1:0] bin;
  logic [`OP_WIDTH-1:0]  alu_op;
  logic [`ALU_WIDTH-1:0] result;
  logic                  branch_taken;
  logic                  done;

  int_alu int_alu_i (
    .clk          (clk),
    .resetn       (resetn),
    .ain          (ain),
    .bin          (bin),
    .alu_op       (alu_op),
    .result       (result),
    .branch_taken (branch_taken),
    .done         (done)
  );

  always #20 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("[FAIL] %s expected %h actual %h", name, expected, actual);
      $display("Simulation finished: FAIL");
      $fatal(1, "value mismatch in %s", name);
    end
  endtask

  function automatic logic [`OP_WIDTH-1:0] one_hot(input alu_op_e op);
    logic [`OP_WIDTH-1:0] word;
    word     = '0;
    word[op] = 1'b1;
    return word;
  endfunction

  function automatic logic [31:0] single_ref(input alu_op_e op, input logic [31:0] a,
                                             input logic [31:0] b);
    case (op)
      op_add:  return a + b;
      op_sub:  return a - b;
      op_sll:  return a << b[4:0];
      op_srl:  return a >> b[4:0];
      op_sra:  return 32'($signed(a) >>> b[4:0]);
      op_or:   return a | b;
      op_and:  return a & b;
      op_xor:  return a ^ b;
      op_slt:  return {31'd0, $signed(a) < $signed(b)};
      op_sltu: return {31'd0, a < b};
      default: return 32'd0;
    endcase
  endfunction

  function automatic logic [31:0] mul_ref(input alu_op_e op, input logic [31:0] a,
                                          input logic [31:0] b);
    logic [63:0] a_s;
    logic [63:0] b_s;
    logic [63:0] a_u;
    logic [63:0] b_u;
    logic [63:0] full;
    a_s = {{32{a[31]}}, a};
    b_s = {{32{b[31]}}, b};
    a_u = {32'd0, a};
    b_u = {32'd0, b};
    case (op)
      op_mulhsu: full = a_s * b_u;
      op_mulhu:  full = a_u * b_u;
      default:   full = a_s * b_s; // low word is the same for every signedness.
    endcase
    return (op == op_mul) ? full[31:0] : full[63:32];
  endfunction

  function automatic logic [31:0] div_ref(input alu_op_e op, input logic [31:0] a,
                                          input logic [31:0] b);
    logic        signed_op;
    logic        want_rem;
    logic [31:0] quo;
    logic [31:0] rem;
    signed_op = (op == op_div) || (op == op_rem);
    want_rem  = (op == op_rem) || (op == op_remu);
    if (b == 32'd0)
    begin
      quo = '1;
      rem = a;
    end
    else if (signed_op && (a == min_int) && (b == '1))
    begin
      quo = a;
      rem = '0;
    end
    else if (signed_op)
    begin
      quo = 32'($signed(a) / $signed(b)); // truncates toward zero as RISC-V does.
      rem = 32'($signed(a) % $signed(b));
    end
    else
    begin
      quo = a / b;
      rem = a % b;
    end
    return want_rem ? rem : quo;
  endfunction

  task automatic drive_op(input logic [31:0] a, input logic [31:0] b,
                          input logic [`OP_WIDTH-1:0] op);
    @(posedge clk);
    ain    <= a;
    bin    <= b;
    alu_op <= op;
  endtask

  task automatic release_op();
    @(posedge clk);
    alu_op <= '0;
  endtask

  task automatic wait_for_done(input string name, output int edges);
    logic seen;
    seen  = 1'b0;
    edges = 0;
    while (!seen && (edges < timeout_cycles))
    begin
      @(posedge clk);
      edges++;
      #1;
      seen = done;
    end
    if (!seen)
    begin
      $display("%s: done never came within %0d cycles.", name, timeout_cycles);
      $display("Simulation finished: FAIL");
      $fatal(1, "timeout waiting for done");
    end
  endtask

  task automatic run_multi(input string name, input logic [31:0] a, input logic [31:0] b,
                           input alu_op_e op, input int latency, input logic [31:0] expected);
    int edges;
    drive_op(a, b, one_hot(op));
    wait_for_done(name, edges);
    check_value({name, " latency"}, 32'(latency), 32'(edges));
    check_value(name, expected, result);
    release_op();
    #1;
    check_value({name, " done pulse"}, 32'd0, 32'(done)); // done lasts one cycle.
  endtask

  task automatic reset_state();
    @(posedge clk);
    #1;
    check_value("reset_state done", 32'd0, 32'(done));
    check_value("reset_state branch_taken", 32'd0, 32'(branch_taken));
    check_value("reset_state result", 32'd0, result);
  endtask

  task automatic single_cycle_ops();
    alu_op_e     ops [10];
    logic [31:0] a;
    logic [31:0] b;
    ops = '{op_add, op_sub, op_sll, op_srl, op_sra, op_or, op_and, op_xor, op_slt, op_sltu};
    for (int i = 0; i < 8; i++)
    begin
      a = $urandom;
      b = (i == 1) ? a : $urandom;
      foreach (ops[k])
      begin
        drive_op(a, b, one_hot(ops[k]));
        #1;
        check_value($sformatf("single_cycle_ops %s", ops[k].name()),
                    single_ref(ops[k], a, b), result);
        check_value("single_cycle_ops done", 32'd0, 32'(done));
      end
    end
    release_op();
  endtask

  task automatic branch_compare();
    logic [31:0]          pair_a [6];
    logic [31:0]          pair_b [6];
    logic [`OP_WIDTH-1:0] word;
    logic                 sense;
    logic                 outcome;
    logic                 expected;
    pair_a = '{32'd5, 32'd3, 32'd7, 32'hffff_ffff, 32'd1, min_int};
    pair_b = '{32'd5, 32'd7, 32'd3, 32'd1, 32'hffff_ffff, 32'h7fff_ffff};
    for (int p = 0; p < 6; p++)
    begin
      for (int v = 0; v < 6; v++)
      begin
        word  = one_hot(op_branch);
        sense = (v % 2 == 0); // even variants are beq and blt.
        case (v / 2)
          0:       word[op_sub] = 1'b1;
          1:       word[op_slt] = 1'b1;
          default: word[op_sltu] = 1'b1;
        endcase
        if (v / 2 == 0)
          word[op_beq] = sense;
        else
          word[op_blt] = sense;
        case (v / 2)
          0:       outcome = (pair_a[p] == pair_b[p]);
          1:       outcome = ($signed(pair_a[p]) < $signed(pair_b[p]));
          default: outcome = (pair_a[p] < pair_b[p]);
        endcase
        expected = sense ? outcome : ~outcome;
        drive_op(pair_a[p], pair_b[p], word);
        #1;
        check_value($sformatf("branch_compare pair %0d variant %0d", p, v),
                    32'(expected), 32'(branch_taken));
      end
    end
    release_op();
  endtask

  task automatic multiply_variants();
    alu_op_e     ops [4];
    logic [31:0] pair_a [8];
    logic [31:0] pair_b [8];
    ops    = '{op_mul, op_mulh, op_mulhsu, op_mulhu};
    pair_a = '{min_int, min_int, 32'hffff_ffff, 32'd0, 32'h7fff_ffff, 32'd0, 32'd0, 32'd0};
    pair_b = '{min_int, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff, min_int,
               32'd0, 32'd0, 32'd0};
    for (int p = 5; p < 8; p++)
    begin
      pair_a[p] = $urandom;
      pair_b[p] = $urandom;
    end
    foreach (ops[k])
    begin
      for (int p = 0; p < 8; p++)
      begin
        run_multi($sformatf("multiply_variants %s pair %0d", ops[k].name(), p),
                  pair_a[p], pair_b[p], ops[k], 5, mul_ref(ops[k], pair_a[p], pair_b[p]));
      end
    end
  endtask

  task automatic divide_variants();
    alu_op_e     ops [4];
    logic [31:0] pair_a [8];
    logic [31:0] pair_b [8];
    ops       = '{op_div, op_divu, op_rem, op_remu};
    pair_a    = '{32'd0, min_int, 32'd0, 32'd0, 32'd0, 32'd0, 32'hffff_ffdb, 32'd0};
    pair_b    = '{32'd0, 32'hffff_ffff, 32'd7, 32'd0, 32'd0, 32'd0, 32'd5, 32'd0};
    pair_a[0] = $urandom; // divide by zero.
    pair_a[3] = $urandom;
    pair_b[3] = $urandom;
    pair_a[4] = $urandom;
    pair_b[4] = ($urandom & 32'h0000_ffff) | 32'd1;
    pair_a[5] = $urandom;
    pair_b[5] = 32'hffff_ff00 | ($urandom & 32'h0000_00ff); // small negative divisor.
    pair_a[7] = $urandom;
    pair_b[7] = $urandom >> 16;
    foreach (ops[k])
    begin
      for (int p = 0; p < 8; p++)
      begin
        run_multi($sformatf("divide_variants %s pair %0d", ops[k].name(), p),
                  pair_a[p], pair_b[p], ops[k], 19, div_ref(ops[k], pair_a[p], pair_b[p]));
      end
    end
  endtask

  task automatic back_to_back();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    a = $urandom;
    b = $urandom;
    c = $urandom;
    d = $urandom >> 8;
    run_multi("back_to_back mulhu", a, b, op_mulhu, 5, mul_ref(op_mulhu, a, b));
    run_multi("back_to_back rem", c, d, op_rem, 19, div_ref(op_rem, c, d));
    run_multi("back_to_back mul", c, a, op_mul, 5, mul_ref(op_mul, c, a));
  endtask

  initial
  begin
    void'($urandom(32'h928c4abb));
    resetn <= 1'b0;
    ain    <= '0;
    bin    <= '0;
    alu_op <= '0;
    repeat (8) @(posedge clk);
    resetn <= 1'b1;
    reset_state();
    single_cycle_ops();
    branch_compare();
    multiply_variants();
    divide_variants();
    back_to_back();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

/* all.f */
+incdir+include
source/alu_pkg.sv
source/iterate_if.sv
source/step_counter.sv
source/alu_sequencer.sv
source/chunk_multiplier.sv
source/radix4_divider.sv
source/barrel_shifter.sv
source/alu_datapath.sv
source/int_alu.sv
bench/int_alu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and decide pass or fail from the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --timescale 1ns/1ps --top-module int_alu_tb -f all.f \
  -o int_alu_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/int_alu_sim > sim.log 2>&1
cat sim.log
grep -q "^Simulation finished: PASS$" sim.log && exit 0 || exit 1
